/* common/bitmap_mem_if.sv */
// ----------------------------
// write and read signals between the command engine and the flag RAM
// the engine drives the request side, the RAM returns read data
// ----------------------------

`timescale 1ns/10ps

interface bitmap_mem_if
   import bitmap_pkg::*;
#(
   parameter int WORDS = BITMAP_WORDS_DEF
);

   // address width follows the depth, so any depth of 2 or more fits
   localparam int AW = $clog2(WORDS);

   // write side, one masked word per cycle
   logic          w_v;
   bitmap_word_t  w_mask;
   logic [AW-1:0] w_addr;
   bitmap_word_t  w_data;

   // read side, r_data appears in the cycle after r_v
   logic          r_v;
   logic [AW-1:0] r_addr;
   bitmap_word_t  r_data;

   modport engine (output w_v, w_mask, w_addr, w_data, r_v, r_addr, input r_data);

   modport mem (input w_v, w_mask, w_addr, w_data, r_v, r_addr, output r_data);

endinterface : bitmap_mem_if

/* common/bitmap_pkg.sv */
// ----------------------------
// shared widths, types and command codes for the flag store
// imported by every RTL block and by the testbench
// ----------------------------

package bitmap_pkg;

   // width of one flag word, fixed because the typed word ports depend on it
   localparam int BITMAP_W = 32;

   // default number of words in the store
   // the top level can override this through its WORDS parameter
   localparam int BITMAP_WORDS_DEF = 16;

   // one flag word
   // the same type carries command masks and the protect mask
   typedef logic [BITMAP_W-1:0] bitmap_word_t;

   // command codes seen on the command port
   // write loads data under the mask, set and clear force the masked bits,
   // read returns the whole word one cycle later
   typedef enum logic [1:0]
   {
      OP_WRITE = 2'd0,
      OP_SET   = 2'd1,
      OP_CLEAR = 2'd2,
      OP_READ  = 2'd3
   } bitmap_op_e;

endpackage : bitmap_pkg

/* compile.f */
common/bitmap_pkg.sv
common/bitmap_mem_if.sv
mem/bitmap_mem.sv
logic/bitmap_cfg_regs.sv
logic/bitmap_cmd_engine.sv
logic/bitmap_top.sv
sim/bitmap_tb.sv

/* logic/bitmap_cfg_regs.sv */
// ----------------------------
// write-protect mask and sticky protect-hit status
// loaded from the config port, the hit bit is fed by the command engine
// ----------------------------

`timescale 1ns/10ps

module bitmap_cfg_regs
   import bitmap_pkg::*;
(
   input  logic          clk_i,
   input  logic          rst_n_i,

   // configuration write, loads a new protect mask
   input  logic          cfg_we_i,
   input  bitmap_word_t  cfg_protect_i,

   // pulse from the engine when a command mask overlapped the protect mask
   input  logic          prot_touch_i,

   output bitmap_word_t  protect_o,
   output logic          prot_hit_o
);

   bitmap_word_t  protect_q;
   logic          prot_hit_q;

   // protect mask register, all bits writable after reset
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         protect_q <= '0;
      end
      else if (cfg_we_i)
      begin
         protect_q <= cfg_protect_i;
      end
   end

   // sticky hit bit
   // a touch always wins over the clear from a config write in the same cycle,
   // so software never loses a hit that raced with its reconfiguration
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         prot_hit_q <= 1'b0;
      end
      else if (prot_touch_i)
      begin
         prot_hit_q <= 1'b1;
      end
      else if (cfg_we_i)
      begin
         prot_hit_q <= 1'b0;
      end
   end

   assign protect_o  = protect_q;
   assign prot_hit_o = prot_hit_q;

endmodule : bitmap_cfg_regs

/* logic/bitmap_cmd_engine.sv */
// ----------------------------
// decodes flag commands into masked RAM writes and reads
// protected bits are stripped from every write, reads return after one cycle
// ----------------------------

`timescale 1ns/10ps

module bitmap_cmd_engine
   import bitmap_pkg::*;
#(
   parameter int WORDS = BITMAP_WORDS_DEF
)
(
   input  logic                      clk_i,
   input  logic                      rst_n_i,

   // command port, one strobe per cycle and never stalled
   input  logic                      cmd_v_i,
   input  bitmap_op_e                cmd_op_i,
   input  logic [$clog2(WORDS)-1:0]  cmd_addr_i,
   input  bitmap_word_t              cmd_mask_i,
   input  bitmap_word_t              cmd_data_i,

   // current protect mask from the config block
   input  bitmap_word_t              protect_i,

   // one-cycle pulse when a modifying command hit a protected bit
   output logic                      prot_touch_o,

   // read response, valid the cycle after the read was accepted
   output logic                      rd_v_o,
   output bitmap_word_t              rd_data_o,

   bitmap_mem_if.engine              mem_if
);

   logic          is_read;
   logic          rd_acc;
   logic          wr_acc;
   bitmap_word_t  eff_mask;
   bitmap_word_t  wr_data;
   logic          rd_v_q;

   // split the strobe into a read or a modifying access
   assign is_read = (cmd_op_i == OP_READ);
   assign rd_acc  = cmd_v_i && is_read;
   assign wr_acc  = cmd_v_i && !is_read;

   // protected positions never reach the RAM write mask
   assign eff_mask = cmd_mask_i & ~protect_i;

   // set and clear are writes of a constant word under the mask
   always_comb
   begin
      unique case (cmd_op_i)
         OP_WRITE: wr_data = cmd_data_i;
         OP_SET:   wr_data = '1;
         OP_CLEAR: wr_data = '0;
         // read leaves the write side idle, data is a don't care here
         default:  wr_data = cmd_data_i;
      endcase
   end

   // write side of the RAM
   assign mem_if.w_v    = wr_acc;
   assign mem_if.w_mask = eff_mask;
   assign mem_if.w_addr = cmd_addr_i;
   assign mem_if.w_data = wr_data;

   // read side, the RAM captures the address on this edge
   assign mem_if.r_v    = rd_acc;
   assign mem_if.r_addr = cmd_addr_i;

   // report any overlap of the requested mask with the protect mask
   // even when the effective mask ends up empty
   assign prot_touch_o = wr_acc && (|(cmd_mask_i & protect_i));

   // response valid follows the accepted read by exactly one edge
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         rd_v_q <= 1'b0;
      end
      else
      begin
         rd_v_q <= rd_acc;
      end
   end

   assign rd_v_o = rd_v_q;

   // RAM output already reflects the captured address in this cycle
   assign rd_data_o = mem_if.r_data;

   // a response never appears without a read one cycle earlier
   a_rd_v_after_read : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      rd_v_o |-> $past(cmd_v_i && (cmd_op_i == OP_READ))
   )
   else $error("read response without an accepted read");

endmodule : bitmap_cmd_engine

/* logic/bitmap_top.sv */
// ----------------------------
// top level of the bit-addressable flag store
// ties the config block, command engine and flag RAM to plain ports
// ----------------------------

`timescale 1ns/10ps

module bitmap_top
   import bitmap_pkg::*;
#(
   parameter int WORDS = BITMAP_WORDS_DEF
)
(
   input  logic                      clk_i,
   input  logic                      rst_n_i,

   // command port
   input  logic                      cmd_v_i,
   input  bitmap_op_e                cmd_op_i,
   input  logic [$clog2(WORDS)-1:0]  cmd_addr_i,
   input  bitmap_word_t              cmd_mask_i,
   input  bitmap_word_t              cmd_data_i,

   // configuration port
   input  logic                      cfg_we_i,
   input  bitmap_word_t              cfg_protect_i,

   // status and read response
   output bitmap_word_t              protect_o,
   output logic                      prot_hit_o,
   output logic                      rd_v_o,
   output bitmap_word_t              rd_data_o
);

   // touch pulse from the engine into the sticky status bit
   logic prot_touch;

   // request and response path between engine and RAM
   bitmap_mem_if #(.WORDS(WORDS)) mem_if ();

   bitmap_cfg_regs bitmap_cfg_regs_inst (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .cfg_we_i      (cfg_we_i),
      .cfg_protect_i (cfg_protect_i),
      .prot_touch_i  (prot_touch),
      .protect_o     (protect_o),
      .prot_hit_o    (prot_hit_o)
   );

   // the engine reads the same protect mask that goes out on protect_o
   bitmap_cmd_engine #(
      .WORDS (WORDS)
   ) bitmap_cmd_engine_inst (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .cmd_v_i      (cmd_v_i),
      .cmd_op_i     (cmd_op_i),
      .cmd_addr_i   (cmd_addr_i),
      .cmd_mask_i   (cmd_mask_i),
      .cmd_data_i   (cmd_data_i),
      .protect_i    (protect_o),
      .prot_touch_o (prot_touch),
      .rd_v_o       (rd_v_o),
      .rd_data_o    (rd_data_o),
      .mem_if       (mem_if.engine)
   );

   bitmap_mem #(
      .WORDS (WORDS)
   ) bitmap_mem_inst (
      .clk_i  (clk_i),
      .mem_if (mem_if.mem)
   );

endmodule : bitmap_top

/* mem/bitmap_mem.sv */
// ----------------------------
// one read, one write flag RAM with synchronous read and per-bit write mask
// the read address is captured on the edge, data is muxed after it
// ----------------------------

`timescale 1ns/10ps

module bitmap_mem
   import bitmap_pkg::*;
#(
   parameter int WORDS = BITMAP_WORDS_DEF
)
(
   input logic         clk_i,
   bitmap_mem_if.mem   mem_if
);

   localparam int AW = $clog2(WORDS);

   // the storage array itself, contents are undefined until written
   bitmap_word_t  mem_q [WORDS];

   // read address held from the last accepted read
   logic [AW-1:0] r_addr_q;

   // the address only moves when a read is requested, so the output
   // keeps showing the same word while no new read arrives
   always_ff @(posedge clk_i)
   begin
      if (mem_if.r_v)
      begin
         r_addr_q <= mem_if.r_addr;
      end
   end

   // muxing happens after the edge, so a read sees every write
   // that landed on or before the edge that captured its address
   assign mem_if.r_data = mem_q[r_addr_q];

   // only bits with their mask bit set take the new value
   // all other bits of the addressed word hold
   always_ff @(posedge clk_i)
   begin
      if (mem_if.w_v)
      begin
         for (int i = 0; i < BITMAP_W; i++)
         begin
            if (mem_if.w_mask[i])
            begin
               mem_q[mem_if.w_addr][i] <= mem_if.w_data[i];
            end
         end
      end
   end

   // the engine forwards the command address unchecked
   // so a depth that is not a power of two relies on the command source
   a_w_addr_in_range : assert property (
      @(posedge clk_i) mem_if.w_v |-> (mem_if.w_addr < WORDS)
   )
   else $error("write address %0d beyond depth %0d", mem_if.w_addr, WORDS);

   a_r_addr_in_range : assert property (
      @(posedge clk_i) mem_if.r_v |-> (mem_if.r_addr < WORDS)
   )
   else $error("read address %0d beyond depth %0d", mem_if.r_addr, WORDS);

endmodule : bitmap_mem

/* run.sh */
#!/bin/sh
# builds the flag store testbench with Verilator and runs it
# the exit status is nonzero when the build fails or the testbench stops with $fatal
cd "$(dirname "$0")" && \
verilator --binary --timing --assert -Wno-fatal \
   --top-module bitmap_tb -f compile.f -o bitmap_sim && \
./obj_dir/bitmap_sim || exit 1

/* sim/bitmap_tb.sv */
// ----------------------------
// directed testbench for the flag store top level
// a shadow model predicts every response, checked on the falling edge
// ----------------------------

`timescale 1ns/10ps

module bitmap_tb
   import bitmap_pkg::*;
();

   localparam int WORDS      = BITMAP_WORDS_DEF;
   localparam int AW         = $clog2(WORDS);
   localparam int CLK_PERIOD = 40;
   localparam int N_RAND     = 40;

   // cycles spent by reset and each test, in the order they run
   localparam int TEST_CYCLES = 4 + (2 * WORDS + 8) + (2 * N_RAND + WORDS) + 3 * N_RAND
                                + (27 + WORDS) + 32 + 2;
   localparam int WATCHDOG_CYCLES = TEST_CYCLES + TEST_CYCLES / 2 + 20;

   logic          clk_i;
   logic          rst_n_i;
   logic          cmd_v_i;
   bitmap_op_e    cmd_op_i;
   logic [AW-1:0] cmd_addr_i;
   bitmap_word_t  cmd_mask_i;
   bitmap_word_t  cmd_data_i;
   logic          cfg_we_i;
   bitmap_word_t  cfg_protect_i;
   bitmap_word_t  protect_o;
   logic          prot_hit_o;
   logic          rd_v_o;
   bitmap_word_t  rd_data_o;

   // shadow state that follows the DUT one edge at a time
   bitmap_word_t  shadow_mem [WORDS];
   bitmap_word_t  shadow_protect;
   logic          shadow_hit;
   logic          rd_pending;
   bitmap_word_t  rd_expect;

   integer        seed;
   string         test_name;

   bitmap_top #(
      .WORDS (WORDS)
   ) bitmap_top_inst (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .cmd_v_i       (cmd_v_i),
      .cmd_op_i      (cmd_op_i),
      .cmd_addr_i    (cmd_addr_i),
      .cmd_mask_i    (cmd_mask_i),
      .cmd_data_i    (cmd_data_i),
      .cfg_we_i      (cfg_we_i),
      .cfg_protect_i (cfg_protect_i),
      .protect_o     (protect_o),
      .prot_hit_o    (prot_hit_o),
      .rd_v_o        (rd_v_o),
      .rd_data_o     (rd_data_o)
   );

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   // the run is bounded by the total cycle count of all tests plus a margin
   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired, the tests did not finish in time");
      $display("Verification failed");
      $fatal(1, "run stopped by the watchdog");
   end

   task automatic check_equal(input string what, input bitmap_word_t expected,
                              input bitmap_word_t actual);
      if (expected !== actual)
      begin
         $display("CHECK FAILED [%s] %s: expected %h, actual %h",
                  test_name, what, expected, actual);
         $display("Verification failed");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   function automatic bitmap_word_t rand_word();
      return $random(seed);
   endfunction

   function automatic logic [AW-1:0] rand_addr();
      int unsigned r;
      r = $random(seed);
      return AW'(r % WORDS);
   endfunction

   // picks one of the three modifying commands
   function automatic bitmap_op_e rand_modify_op();
      int unsigned r;
      r = $random(seed);
      case (r % 3)
         0: return OP_WRITE;
         1: return OP_SET;
         default: return OP_CLEAR;
      endcase
   endfunction

   // compares the outputs of the current cycle with the shadow state
   task automatic check_outputs();
      check_equal("rd_v_o", 32'(rd_pending), 32'(rd_v_o));
      if (rd_pending)
      begin
         check_equal("rd_data_o", rd_expect, rd_data_o);
      end
      check_equal("prot_hit_o", 32'(shadow_hit), 32'(prot_hit_o));
      check_equal("protect_o", shadow_protect, protect_o);
   endtask

   // one clock cycle: check the last edge, drive new inputs, advance the model
   task automatic next_cycle(input logic v, input bitmap_op_e op, input logic [AW-1:0] addr,
                             input bitmap_word_t mask, input bitmap_word_t data,
                             input logic cfg_we, input bitmap_word_t cfg_prot);
      bitmap_word_t eff;
      bitmap_word_t val;
      logic         touch;
      @(negedge clk_i);
      check_outputs();
      cmd_v_i       = v;
      cmd_op_i      = op;
      cmd_addr_i    = addr;
      cmd_mask_i    = mask;
      cmd_data_i    = data;
      cfg_we_i      = cfg_we;
      cfg_protect_i = cfg_prot;
      touch = 1'b0;
      // a read sees the word as it stands before any later command
      rd_pending = v && (op == OP_READ);
      if (rd_pending)
      begin
         rd_expect = shadow_mem[addr];
      end
      if (v && (op != OP_READ))
      begin
         // the protect mask in force is the one before this edge
         eff = mask & ~shadow_protect;
         case (op)
            OP_WRITE: val = data;
            OP_SET:   val = '1;
            default:  val = '0;
         endcase
         shadow_mem[addr] = (shadow_mem[addr] & ~eff) | (val & eff);
         touch = |(mask & shadow_protect);
      end
      // a touch in the same cycle beats the clear of a config write
      if (touch)
      begin
         shadow_hit = 1'b1;
      end
      else if (cfg_we)
      begin
         shadow_hit = 1'b0;
      end
      if (cfg_we)
      begin
         shadow_protect = cfg_prot;
      end
   endtask

   task automatic send_cmd(input bitmap_op_e op, input logic [AW-1:0] addr,
                           input bitmap_word_t mask, input bitmap_word_t data);
      next_cycle(1'b1, op, addr, mask, data, 1'b0, '0);
   endtask

   task automatic read_word(input logic [AW-1:0] addr);
      send_cmd(OP_READ, addr, '0, '0);
   endtask

   task automatic idle_cycle();
      next_cycle(1'b0, OP_WRITE, '0, '0, '0, 1'b0, '0);
   endtask

   task automatic load_protect(input bitmap_word_t prot);
      next_cycle(1'b0, OP_WRITE, '0, '0, '0, 1'b1, prot);
   endtask

   // reset values, then fill every word and stream it back
   task automatic test_reset_readback();
      test_name = "reset_readback";
      check_equal("rd_v_o after reset", '0, 32'(rd_v_o));
      check_equal("prot_hit_o after reset", '0, 32'(prot_hit_o));
      check_equal("protect_o after reset", '0, protect_o);
      for (int a = 0; a < WORDS; a++)
      begin
         send_cmd(OP_WRITE, AW'(a), '1, rand_word());
      end
      // back-to-back reads, one response per cycle
      for (int a = 0; a < WORDS; a++)
      begin
         read_word(AW'(a));
      end
      // single reads with an idle gap after each
      for (int i = 0; i < 4; i++)
      begin
         read_word(rand_addr());
         idle_cycle();
      end
   endtask

   task automatic test_masked_write();
      logic [AW-1:0] addr;
      test_name = "masked_write";
      for (int i = 0; i < N_RAND; i++)
      begin
         addr = rand_addr();
         send_cmd(OP_WRITE, addr, rand_word(), rand_word());
         read_word(addr);
      end
      for (int a = 0; a < WORDS; a++)
      begin
         read_word(AW'(a));
      end
   endtask

   task automatic test_set_clear();
      logic [AW-1:0] addr;
      bitmap_op_e    op;
      test_name = "set_clear";
      for (int i = 0; i < N_RAND; i++)
      begin
         addr = rand_addr();
         op   = ($random(seed) & 1) ? OP_SET : OP_CLEAR;
         send_cmd(op, addr, rand_word(), rand_word());
         idle_cycle();
         read_word(addr);
      end
   endtask

   task automatic test_protect();
      logic [AW-1:0] addr;
      test_name = "protect";
      load_protect(rand_word() | 32'h0000_0001);
      // reads alone must leave the status low
      for (int i = 0; i < 4; i++)
      begin
         read_word(rand_addr());
      end
      addr = rand_addr();
      send_cmd(OP_SET, addr, rand_word() | 32'h0000_0001, '0);
      read_word(addr);
      // full masks hit every protected bit, the status stays high
      for (int i = 0; i < 6; i++)
      begin
         addr = rand_addr();
         send_cmd(rand_modify_op(), addr, '1, rand_word());
         read_word(addr);
      end
      // a config write clears the status
      load_protect(rand_word() | 32'h8000_0000);
      for (int i = 0; i < 4; i++)
      begin
         read_word(rand_addr());
      end
      // touch and config write in the same cycle, the touch wins
      addr = rand_addr();
      next_cycle(1'b1, OP_CLEAR, addr, '1, '0, 1'b1, 32'h0000_ffff);
      read_word(addr);
      load_protect('0);
      for (int a = 0; a < WORDS; a++)
      begin
         read_word(AW'(a));
      end
   endtask

   // a read right behind a modify of the same word sees the new value
   task automatic test_read_after_write();
      logic [AW-1:0] addr;
      test_name = "read_after_write";
      for (int i = 0; i < 8; i++)
      begin
         addr = rand_addr();
         send_cmd(OP_WRITE, addr, '1, rand_word());
         read_word(addr);
         send_cmd(rand_modify_op(), addr, rand_word(), rand_word());
         read_word(addr);
      end
   endtask

   initial
   begin
      seed           = 32'h219e_bb8c;
      test_name      = "init";
      clk_i          = 1'b0;
      rst_n_i        = 1'b0;
      cmd_v_i        = 1'b0;
      cmd_op_i       = OP_WRITE;
      cmd_addr_i     = '0;
      cmd_mask_i     = '0;
      cmd_data_i     = '0;
      cfg_we_i       = 1'b0;
      cfg_protect_i  = '0;
      shadow_protect = '0;
      shadow_hit     = 1'b0;
      rd_pending     = 1'b0;
      rd_expect      = '0;
      repeat (4) @(negedge clk_i);
      rst_n_i = 1'b1;
      test_reset_readback();
      test_masked_write();
      test_set_clear();
      test_protect();
      test_read_after_write();
      // let the last response come out and be checked
      idle_cycle();
      idle_cycle();
      $display("Verification passed");
      $finish;
   end

endmodule : bitmap_tb
